// ==== filelist.f ====
hw/fm_pkg.sv
hw/acc_pkg.sv
hw/occ_credit_port.sv
hw/task_queue.sv
hw/result_regfile.sv
hw/read_rom.sv
hw/search_fsm.sv
hw/fm_accel_top.sv
tests/tb_checker.sv
tests/tb_fm_accel.sv

// ==== hw/acc_pkg.sv ====
//////////////////////////////////////////////////
// accelerator word layouts and sizes
//////////////////////////////////////////////////

package acc_pkg;

    // task queue
    localparam int TASK_DEPTH = 16;
    localparam int TASK_AW    = 4;

    // task word, msb first
    // rsvd[31:28] tag[27:24] start[23:16] len[15:8] spare[7:0]
    localparam int TASK_W         = 32;
    localparam int TASK_TAG_LSB   = 24;
    localparam int TASK_START_LSB = 16;
    localparam int TASK_LEN_LSB   = 8;

    // result word, msb first
    // valid[17] found[16] lo[15:8] hi[7:0]
    localparam int RES_W         = 18;
    localparam int RES_AW        = 4;
    localparam int RES_VALID_BIT = 17;
    localparam int RES_FOUND_BIT = 16;
    localparam int RES_LO_LSB    = 8;

    // occ flow control
    localparam int OCC_CREDITS = 2;
    localparam int CRED_W      = $clog2(OCC_CREDITS + 1);
    localparam int OCC_PTR_W   = $clog2(OCC_CREDITS);   // depth is a power of two

    // search controller states
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [ST_W-1:0] ST_FETCH   = 3'd1;
    localparam logic [ST_W-1:0] ST_CREAD   = 3'd2;
    localparam logic [ST_W-1:0] ST_ISSUE   = 3'd3;
    localparam logic [ST_W-1:0] ST_COLLECT = 3'd4;
    localparam logic [ST_W-1:0] ST_UPDATE  = 3'd5;
    localparam logic [ST_W-1:0] ST_WRITE   = 3'd6;
    localparam logic [ST_W-1:0] ST_DONE    = 3'd7;

endpackage

// ==== hw/fm_accel_top.sv ====
module fm_accel_top (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          start_i,
    output logic                          busy_o,
    output logic                          done_o,
    // host task loading
    input  logic                          task_we_i,
    input  logic [acc_pkg::TASK_AW-1:0]   task_waddr_i,
    input  logic [acc_pkg::TASK_W-1:0]    task_wdata_i,
    // host result read back
    input  logic [acc_pkg::RES_AW-1:0]    res_raddr_i,
    output logic [acc_pkg::RES_W-1:0]     res_rdata_o,
    // c memory, one cycle rom
    output logic                          c_ce_o,
    output logic [fm_pkg::C_ADDR_W-1:0]   c_addr_o,
    input  logic [fm_pkg::POS_W-1:0]      c_data_i,
    // occ memory, variable latency
    output logic                          occ_req_o,
    output logic [fm_pkg::POS_W-1:0]      occ_addr_o,
    input  logic [fm_pkg::OCC_W-1:0]      occ_data_i,
    input  logic                          occ_valid_i
);

    // controller <-> task queue
    logic                          q_re;
    logic                          q_empty;
    logic [acc_pkg::TASK_W-1:0]    task_word;

    // controller <-> read store
    logic [fm_pkg::POS_W-1:0]      pos;
    logic [fm_pkg::SYM_W-1:0]      sym;

    // controller <-> occ port
    logic                          occ_req;
    logic [fm_pkg::POS_W-1:0]      occ_addr;
    logic                          occ_can_req;
    logic                          occ_rsp_valid;
    logic [fm_pkg::OCC_W-1:0]      occ_rsp_data;
    logic                          occ_pop;

    // controller -> result file
    logic                          res_we;
    logic [acc_pkg::RES_AW-1:0]    res_waddr;
    logic [acc_pkg::RES_W-1:0]     res_wdata;

    search_fsm u_search_fsm (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .start_i         (start_i),
        .q_empty_i       (q_empty),
        .task_i          (task_word),
        .sym_i           (sym),
        .c_data_i        (c_data_i),
        .occ_can_req_i   (occ_can_req),
        .occ_rsp_valid_i (occ_rsp_valid),
        .occ_rsp_data_i  (occ_rsp_data),
        .busy_o          (busy_o),
        .done_o          (done_o),
        .q_re_o          (q_re),
        .pos_o           (pos),
        .c_ce_o          (c_ce_o),
        .c_addr_o        (c_addr_o),
        .occ_req_o       (occ_req),
        .occ_addr_o      (occ_addr),
        .occ_pop_o       (occ_pop),
        .res_we_o        (res_we),
        .res_waddr_o     (res_waddr),
        .res_wdata_o     (res_wdata)
    );

    task_queue u_task_queue (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .host_we_i    (task_we_i),
        .host_waddr_i (task_waddr_i),
        .host_wdata_i (task_wdata_i),
        .seq_re_i     (q_re),
        .empty_o      (q_empty),
        .task_o       (task_word)
    );

    result_regfile u_result_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (res_we),
        .waddr_i  (res_waddr),
        .wdata_i  (res_wdata),
        .raddr_i  (res_raddr_i),
        .rdata_o  (res_rdata_o)
    );

    read_rom u_read_rom (
        .pos_i (pos),
        .sym_o (sym)
    );

    // credit gate in front of the external occ memory
    occ_credit_port u_occ_credit_port (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (occ_req),
        .addr_i      (occ_addr),
        .occ_data_i  (occ_data_i),
        .occ_valid_i (occ_valid_i),
        .pop_i       (occ_pop),
        .can_req_o   (occ_can_req),
        .occ_req_o   (occ_req_o),
        .occ_addr_o  (occ_addr_o),
        .rsp_valid_o (occ_rsp_valid),
        .rsp_data_o  (occ_rsp_data)
    );

endmodule

// ==== hw/fm_pkg.sv ====
//////////////////////////////////////////////////
// fm-index geometry and symbol coding
//////////////////////////////////////////////////

package fm_pkg;

    // symbols are two bits wide
    // a=0 c=1 g=2 t=3, same order as the c table
    localparam int SYM_W = 2;

    // bwt positions and interval bounds
    localparam int POS_W   = 8;
    localparam int REF_LEN = 255;   // bwt length, first upper bound

    // one occ word packs four counts, symbol a at bits [a*CNT_W +: CNT_W]
    localparam int CNT_W = 8;
    localparam int OCC_W = 4 * CNT_W;

    // read store holds four symbols per byte, lowest bits first
    localparam int RD_BYTES = 64;

    // c table has one entry per symbol
    localparam int C_ADDR_W = 2;

endpackage

// ==== hw/occ_credit_port.sv ====
module occ_credit_port (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       req_i,        // controller wants to issue
    input  logic [fm_pkg::POS_W-1:0]   addr_i,
    input  logic [fm_pkg::OCC_W-1:0]   occ_data_i,
    input  logic                       occ_valid_i,  // in-order answer from occ memory
    input  logic                       pop_i,        // controller consumes head answer
    output logic                       can_req_o,
    output logic                       occ_req_o,
    output logic [fm_pkg::POS_W-1:0]   occ_addr_o,
    output logic                       rsp_valid_o,
    output logic [fm_pkg::OCC_W-1:0]   rsp_data_o
);

    logic [acc_pkg::CRED_W-1:0]    credit_q;   // free slots, outstanding + buffered excluded
    logic [acc_pkg::CRED_W-1:0]    fill_q;     // answers waiting in fifo
    logic [acc_pkg::OCC_PTR_W-1:0] wr_ptr_q;
    logic [acc_pkg::OCC_PTR_W-1:0] rd_ptr_q;
    logic [fm_pkg::OCC_W-1:0]      rsp_mem [acc_pkg::OCC_CREDITS];
    logic                          do_pop;

    assign can_req_o   = (credit_q != '0);
    assign occ_req_o   = req_i & can_req_o;     // no credit, no request
    assign occ_addr_o  = addr_i;
    assign rsp_valid_o = (fill_q != '0);
    assign rsp_data_o  = rsp_mem[rd_ptr_q];
    assign do_pop      = pop_i & rsp_valid_o;   // ignore pops on empty fifo

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q <= acc_pkg::CRED_W'(acc_pkg::OCC_CREDITS);
            fill_q   <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            // credit leaves on request, comes back when the entry is freed
            if (occ_req_o && !do_pop) credit_q <= credit_q - 1'b1;
            if (!occ_req_o && do_pop) credit_q <= credit_q + 1'b1;
            if (occ_valid_i && !do_pop) fill_q <= fill_q + 1'b1;
            if (!occ_valid_i && do_pop) fill_q <= fill_q - 1'b1;
            if (occ_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps naturally
            if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // fifo storage, sized by credits so it never overflows
    always_ff @(posedge clk) begin
        if (occ_valid_i) rsp_mem[wr_ptr_q] <= occ_data_i;
    end

endmodule

// ==== hw/read_rom.sv ====
module read_rom (
    input  logic [fm_pkg::POS_W-1:0] pos_i,   // symbol position in the store
    output logic [fm_pkg::SYM_W-1:0] sym_o
);

    logic [4*fm_pkg::SYM_W-1:0] rd_mem [fm_pkg::RD_BYTES];
    logic [4*fm_pkg::SYM_W-1:0] byte_sel;

    // packed reads, four symbols per byte
    initial begin
        $readmemh("reads.mem", rd_mem);
    end

    assign byte_sel = rd_mem[pos_i[fm_pkg::POS_W-1:2]];                // pos / 4
    assign sym_o    = byte_sel[pos_i[1:0]*fm_pkg::SYM_W +: fm_pkg::SYM_W]; // low field first

endmodule

// ==== hw/result_regfile.sv ====
module result_regfile (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        we_i,      // from search controller
    input  logic [acc_pkg::RES_AW-1:0]  waddr_i,   // result tag
    input  logic [acc_pkg::RES_W-1:0]   wdata_i,
    input  logic [acc_pkg::RES_AW-1:0]  raddr_i,   // host read address
    output logic [acc_pkg::RES_W-1:0]   rdata_o
);

    // valid kept apart so reset can clear it alone
    logic [2**acc_pkg::RES_AW-1:0]    valid_q;
    logic [acc_pkg::RES_VALID_BIT-1:0] word_mem [2**acc_pkg::RES_AW];   // found, lo, hi

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[waddr_i] <= wdata_i[acc_pkg::RES_VALID_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) word_mem[waddr_i] <= wdata_i[acc_pkg::RES_VALID_BIT-1:0];
        rdata_o <= {valid_q[raddr_i], word_mem[raddr_i]};   // one cycle read
    end

endmodule

// ==== hw/search_fsm.sv ====
module search_fsm (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          start_i,
    // task queue
    input  logic                          q_empty_i,
    input  logic [acc_pkg::TASK_W-1:0]    task_i,
    // read store
    input  logic [fm_pkg::SYM_W-1:0]      sym_i,
    // c memory
    input  logic [fm_pkg::POS_W-1:0]      c_data_i,
    // occ credit port
    input  logic                          occ_can_req_i,
    input  logic                          occ_rsp_valid_i,
    input  logic [fm_pkg::OCC_W-1:0]      occ_rsp_data_i,
    output logic                          busy_o,
    output logic                          done_o,
    output logic                          q_re_o,
    output logic [fm_pkg::POS_W-1:0]      pos_o,
    output logic                          c_ce_o,
    output logic [fm_pkg::C_ADDR_W-1:0]   c_addr_o,
    output logic                          occ_req_o,
    output logic [fm_pkg::POS_W-1:0]      occ_addr_o,
    output logic                          occ_pop_o,
    // result file
    output logic                          res_we_o,
    output logic [acc_pkg::RES_AW-1:0]    res_waddr_o,
    output logic [acc_pkg::RES_W-1:0]     res_wdata_o
);

    logic [acc_pkg::ST_W-1:0]  state_q;
    logic [fm_pkg::POS_W-1:0]  step_q;     // symbols already consumed
    logic                      lo_sent_q;  // lo request out, hi is next
    logic                      lo_got_q;   // lo answer already taken
    logic                      found_q;
    logic                      c_ce_q;     // c data arrives this cycle

    logic [fm_pkg::POS_W-1:0]  lo_q;
    logic [fm_pkg::POS_W-1:0]  hi_q;
    logic [fm_pkg::POS_W-1:0]  c_q;
    logic [fm_pkg::SYM_W-1:0]  sym_q;

    // task fields, task_i stays put until the next fetch
    logic [fm_pkg::POS_W-1:0]   t_start;
    logic [fm_pkg::POS_W-1:0]   t_len;
    logic [acc_pkg::RES_AW-1:0] t_tag;
    logic [fm_pkg::CNT_W-1:0]   occ_cnt;

    assign t_start = task_i[acc_pkg::TASK_START_LSB +: fm_pkg::POS_W];
    assign t_len   = task_i[acc_pkg::TASK_LEN_LSB +: fm_pkg::POS_W];
    assign t_tag   = task_i[acc_pkg::TASK_TAG_LSB +: acc_pkg::RES_AW];
    assign occ_cnt = occ_rsp_data_i[sym_q*fm_pkg::CNT_W +: fm_pkg::CNT_W];   // count of symbol a

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign busy_o     = (state_q != acc_pkg::ST_IDLE);
    assign done_o     = (state_q == acc_pkg::ST_DONE);
    assign q_re_o     = (state_q == acc_pkg::ST_FETCH) && !q_empty_i;
    assign pos_o      = t_start + t_len - 1'b1 - step_q;   // walk from last symbol down
    assign c_ce_o     = (state_q == acc_pkg::ST_CREAD);
    assign c_addr_o   = sym_i;
    assign occ_req_o  = (state_q == acc_pkg::ST_ISSUE) && occ_can_req_i;
    assign occ_addr_o = lo_sent_q ? hi_q : lo_q;           // lo first, then hi
    assign occ_pop_o  = (state_q == acc_pkg::ST_COLLECT) && occ_rsp_valid_i;
    assign res_we_o   = (state_q == acc_pkg::ST_WRITE);
    assign res_waddr_o = t_tag;

    always_comb begin
        res_wdata_o = '0;
        res_wdata_o[acc_pkg::RES_VALID_BIT]             = 1'b1;
        res_wdata_o[acc_pkg::RES_FOUND_BIT]             = found_q;
        res_wdata_o[acc_pkg::RES_LO_LSB +: fm_pkg::POS_W] = lo_q;
        res_wdata_o[0 +: fm_pkg::POS_W]                 = hi_q;
    end

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= acc_pkg::ST_IDLE;
            step_q    <= '0;
            lo_sent_q <= 1'b0;
            lo_got_q  <= 1'b0;
            found_q   <= 1'b0;
            c_ce_q    <= 1'b0;
        end else begin
            c_ce_q <= c_ce_o;
            case (state_q)
                acc_pkg::ST_IDLE: begin
                    if (start_i) state_q <= acc_pkg::ST_FETCH;   // only taken when idle
                end
                acc_pkg::ST_FETCH: begin
                    step_q  <= '0;
                    state_q <= q_empty_i ? acc_pkg::ST_DONE : acc_pkg::ST_CREAD;
                end
                acc_pkg::ST_CREAD: begin
                    state_q <= acc_pkg::ST_ISSUE;
                end
                acc_pkg::ST_ISSUE: begin
                    // waits here while out of credits
                    if (occ_req_o) begin
                        lo_sent_q <= !lo_sent_q;
                        if (lo_sent_q) state_q <= acc_pkg::ST_COLLECT;
                    end
                end
                acc_pkg::ST_COLLECT: begin
                    if (occ_pop_o) begin
                        lo_got_q <= !lo_got_q;
                        if (lo_got_q) state_q <= acc_pkg::ST_UPDATE;   // second answer is hi
                    end
                end
                acc_pkg::ST_UPDATE: begin
                    if (lo_q >= hi_q) begin
                        found_q <= 1'b0;   // interval empty, stop early
                        state_q <= acc_pkg::ST_WRITE;
                    end else if (step_q == t_len - 1'b1) begin
                        found_q <= 1'b1;
                        state_q <= acc_pkg::ST_WRITE;
                    end else begin
                        step_q  <= step_q + 1'b1;
                        state_q <= acc_pkg::ST_CREAD;
                    end
                end
                acc_pkg::ST_WRITE: begin
                    state_q <= acc_pkg::ST_FETCH;   // next task or drain
                end
                default: begin
                    state_q <= acc_pkg::ST_IDLE;    // done lasts one cycle
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // interval datapath
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state_q == acc_pkg::ST_FETCH) begin
            lo_q <= '0;
            hi_q <= fm_pkg::POS_W'(fm_pkg::REF_LEN);
        end
        if (state_q == acc_pkg::ST_CREAD) sym_q <= sym_i;
        if (c_ce_q) c_q <= c_data_i;   // one cycle after ce
        // hi request already went out, so lo can move at once
        if (occ_pop_o) begin
            if (lo_got_q) hi_q <= c_q + occ_cnt;
            else          lo_q <= c_q + occ_cnt;
        end
    end

endmodule

// ==== hw/task_queue.sv ====
module task_queue (
    input  logic                         clk,
    input  logic                         arst_n_i,
    // host random write port
    input  logic                         host_we_i,
    input  logic [acc_pkg::TASK_AW-1:0]  host_waddr_i,
    input  logic [acc_pkg::TASK_W-1:0]   host_wdata_i,
    // controller side, sequential read
    input  logic                         seq_re_i,
    output logic                         empty_o,
    output logic [acc_pkg::TASK_W-1:0]   task_o
);

    logic [acc_pkg::TASK_W-1:0] task_mem [acc_pkg::TASK_DEPTH];

    // one extra bit so a full wrap is not seen as empty
    logic [acc_pkg::TASK_AW:0] wr_cnt_q;   // writes since reset
    logic [acc_pkg::TASK_AW:0] rd_ptr_q;   // next task to hand out

    assign empty_o = (rd_ptr_q == wr_cnt_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_cnt_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (host_we_i) wr_cnt_q <= wr_cnt_q + 1'b1;
            if (seq_re_i && !empty_o) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // storage and registered read
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (host_we_i) task_mem[host_waddr_i] <= host_wdata_i;
        // held until the next sequential read
        if (seq_re_i) task_o <= task_mem[rd_ptr_q[acc_pkg::TASK_AW-1:0]];
    end

endmodule

// ==== reads.mem ====
// packed read store, 64 bytes, four 2-bit symbols per byte
// symbol n of a byte sits at bits [2n+1:2n], a=0 c=1 g=2 t=3
1b e4 72 c9
3d 8a 56 f0
a7 19 c4 6e
52 bd 08 93
e1 4c 7a 2f
96 35 d8 0b
6c f2 47 a1
d4 8e 13 59
25 c7 b0 7d
f8 61 9a 3e
0d 54 e9 b6
8b 2a 76 c3
47 fd 15 60
b2 98 3f d1
79 0e a5 4b
c6 23 8f e7

// ==== tests/tb_checker.sv ====
module tb_checker (
    input  logic                        clk,
    input  logic                        arst_n_i,
    // dut host side is only watched here
    input  logic                        task_we_i,
    input  logic [acc_pkg::TASK_W-1:0]  task_wdata_i,
    input  logic                        start_i,
    input  logic                        busy_o,
    input  logic                        done_o,
    input  logic                        c_ce_o,
    input  logic                        occ_req_o,
    input  logic                        rb_i,          // read-back in progress
    input  logic [acc_pkg::RES_AW-1:0]  res_raddr_i,
    input  logic [acc_pkg::RES_W-1:0]   res_rdata_o,
    output logic [31:0]                 val_err_o,
    output logic [31:0]                 proto_err_o
);

    localparam int SLOTS = 2**acc_pkg::RES_AW;

    logic [7:0]                 rd_bytes [fm_pkg::RD_BYTES];   // own copy of the read store
    logic [acc_pkg::RES_W-1:0]  exp_word [SLOTS];    // what the host should read now
    logic [acc_pkg::RES_W-1:0]  pend_word [SLOTS];   // lands at the next done
    logic                       pend_mask [SLOTS];
    logic                       rb_pend;
    logic [acc_pkg::RES_AW-1:0] rb_addr;
    logic                       busy_chk;            // cycle after done
    logic                       run_chk;             // batch started and done not seen yet
    logic [acc_pkg::RES_AW-1:0] tag;
    int                         val_err = 0;
    int                         proto_err = 0;
    int                         starts;
    int                         dones;
    int                         i;

    assign val_err_o   = val_err;
    assign proto_err_o = proto_err;

    initial begin
        $readmemh("reads.mem", rd_bytes);
    end

    //////////////////////////////////////////////////
    // reference backward search
    //////////////////////////////////////////////////

    // symbol n of the store is field n mod 4 of byte n / 4 with the low field first
    function automatic logic [1:0] sym_at(input logic [7:0] pos);
        logic [7:0] byte_v;
        byte_v = rd_bytes[pos / 4];
        return byte_v[(pos % 4) * 2 +: 2];
    endfunction

    // returns {found, lo, hi}
    function automatic logic [16:0] ref_search(input logic [7:0] start, input logic [7:0] len);
        logic [7:0] lo;
        logic [7:0] hi;
        logic [7:0] nlo;
        logic [7:0] nhi;
        logic [7:0] pos;
        logic [1:0] a;
        logic       found;
        int         k;
        lo    = 8'd0;
        hi    = 8'(fm_pkg::REF_LEN);
        found = 1'b1;
        for (k = 0; k < len; k++) begin
            if (found) begin
                pos = start + len - 1 - k;   // last symbol first
                a   = sym_at(pos);
                nlo = tb_fm_accel.c_tab[a] + tb_fm_accel.occ_tab[lo][a*fm_pkg::CNT_W +: 8];
                nhi = tb_fm_accel.c_tab[a] + tb_fm_accel.occ_tab[hi][a*fm_pkg::CNT_W +: 8];
                lo  = nlo;
                hi  = nhi;
                if (lo >= hi) found = 1'b0;   // empty interval keeps this lo and hi
            end
        end
        return {found, lo, hi};
    endfunction

    task automatic compare_slot(input logic [acc_pkg::RES_AW-1:0] slot);
        logic [acc_pkg::RES_W-1:0] got;
        got = res_rdata_o;
        if (!exp_word[slot][acc_pkg::RES_VALID_BIT]) begin
            // only valid is defined before the first write
            if (got[acc_pkg::RES_VALID_BIT] !== 1'b0) begin
                val_err++;
                $display("error res_rdata_o valid slot %0h: got %h expected %h",
                         slot, got[acc_pkg::RES_VALID_BIT], 1'b0);
            end
        end else if (got !== exp_word[slot]) begin
            val_err++;
            $display("error res_rdata_o slot %0h: got %h expected %h",
                     slot, got, exp_word[slot]);
        end
    endtask

    //////////////////////////////////////////////////
    // monitor sampled mid-cycle
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!arst_n_i) begin
            if (busy_o || done_o || c_ce_o || occ_req_o) begin
                proto_err++;
                $display("control outputs were not low while reset was held at %0t", $time);
            end
            for (i = 0; i < SLOTS; i++) begin
                exp_word[i]  = '0;
                pend_mask[i] = 1'b0;
            end
            rb_pend  = 1'b0;
            busy_chk = 1'b0;
            run_chk  = 1'b0;
            starts   = 0;
            dones    = 0;
        end else begin
            if (rb_pend) compare_slot(rb_addr);   // registered read lands one cycle late
            rb_pend = rb_i;
            rb_addr = res_raddr_i;
            if (busy_chk && busy_o) begin
                proto_err++;
                $display("busy stayed high after done at %0t", $time);
            end
            busy_chk = done_o;
            if (done_o) run_chk = 1'b0;
            if (run_chk && !busy_o) begin
                proto_err++;
                $display("busy was low while a batch was still running at %0t", $time);
            end
            if (task_we_i) begin
                tag = task_wdata_i[acc_pkg::TASK_TAG_LSB +: acc_pkg::RES_AW];
                pend_word[tag] = {1'b1, ref_search(
                    task_wdata_i[acc_pkg::TASK_START_LSB +: 8],
                    task_wdata_i[acc_pkg::TASK_LEN_LSB +: 8])};
                pend_mask[tag] = 1'b1;
            end
            if (start_i && !busy_o) begin
                starts++;
                run_chk = 1'b1;   // busy from the next cycle on
            end
            if (done_o) begin
                dones++;
                if (dones != starts) begin
                    proto_err++;
                    $display("done pulsed %0d times for %0d starts", dones, starts);
                end
                // results of the finished batch are now readable
                for (i = 0; i < SLOTS; i++) begin
                    if (pend_mask[i]) exp_word[i] = pend_word[i];
                    pend_mask[i] = 1'b0;
                end
            end
        end
    end

endmodule

// ==== tests/tb_fm_accel.sv ====
module tb_fm_accel;

    localparam int N_TASKS  = 16;
    localparam int WD_LIMIT = N_TASKS * 32 * 40 * 40 + 4000 * 40;   // steps x cycles x period

    logic                          clk = 1'b0;
    logic                          arst_n_i;
    logic                          start_i;
    logic                          busy_o;
    logic                          done_o;
    logic                          task_we_i;
    logic [acc_pkg::TASK_AW-1:0]   task_waddr_i;
    logic [acc_pkg::TASK_W-1:0]    task_wdata_i;
    logic [acc_pkg::RES_AW-1:0]    res_raddr_i;
    logic [acc_pkg::RES_W-1:0]     res_rdata_o;
    logic                          c_ce_o;
    logic [fm_pkg::C_ADDR_W-1:0]   c_addr_o;
    logic [fm_pkg::POS_W-1:0]      c_data_i;
    logic                          occ_req_o;
    logic [fm_pkg::POS_W-1:0]      occ_addr_o;
    logic [fm_pkg::OCC_W-1:0]      occ_data_i;
    logic                          occ_valid_i;
    logic                          rb;                // read-back window for the checker
    logic [31:0]                   val_err;
    logic [31:0]                   proto_err;

    // memory model state
    logic [1:0]                    bwt [fm_pkg::REF_LEN];
    logic [fm_pkg::POS_W-1:0]      c_tab [4];
    logic [fm_pkg::OCC_W-1:0]      occ_tab [256];
    int                            due_q[$];         // answer cycle per request
    logic [fm_pkg::POS_W-1:0]      oaddr_q[$];
    int                            cyc = 0;
    int                            last_due = 0;
    int                            due;
    int                            drop;
    int                            credit_err = 0;
    int unsigned                   seed_val;
    logic                          c_pend;
    logic [fm_pkg::C_ADDR_W-1:0]   c_addr_s;

    always #20 clk = ~clk;

    fm_accel_top DUT (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (start_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .task_we_i    (task_we_i),
        .task_waddr_i (task_waddr_i),
        .task_wdata_i (task_wdata_i),
        .res_raddr_i  (res_raddr_i),
        .res_rdata_o  (res_rdata_o),
        .c_ce_o       (c_ce_o),
        .c_addr_o     (c_addr_o),
        .c_data_i     (c_data_i),
        .occ_req_o    (occ_req_o),
        .occ_addr_o   (occ_addr_o),
        .occ_data_i   (occ_data_i),
        .occ_valid_i  (occ_valid_i)
    );

    tb_checker u_checker (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .task_we_i    (task_we_i),
        .task_wdata_i (task_wdata_i),
        .start_i      (start_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .c_ce_o       (c_ce_o),
        .occ_req_o    (occ_req_o),
        .rb_i         (rb),
        .res_raddr_i  (res_raddr_i),
        .res_rdata_o  (res_rdata_o),
        .val_err_o    (val_err),
        .proto_err_o  (proto_err)
    );

    //////////////////////////////////////////////////
    // c and occ memory models
    //////////////////////////////////////////////////

    // random bwt, c = symbols smaller than a, occ = counts below p
    task automatic build_tables();
        int cnt [4];
        int p;
        int a;
        for (a = 0; a < 4; a++) cnt[a] = 0;
        for (p = 0; p < fm_pkg::REF_LEN; p++) bwt[p] = 2'($urandom_range(0, 3));
        for (p = 0; p < 256; p++) begin
            occ_tab[p] = {8'(cnt[3]), 8'(cnt[2]), 8'(cnt[1]), 8'(cnt[0])};
            if (p < fm_pkg::REF_LEN) cnt[bwt[p]]++;
        end
        c_tab[0] = 8'd0;
        for (a = 1; a < 4; a++) c_tab[a] = c_tab[a-1] + 8'(cnt[a-1]);
    endtask

    always begin
        @(negedge clk);
        c_pend   = arst_n_i && c_ce_o;
        c_addr_s = c_addr_o;
        if (arst_n_i && occ_req_o) begin
            due = cyc + $urandom_range(1, 8);
            if (due <= last_due) due = last_due + 1;   // in order, one answer a cycle
            last_due = due;
            due_q.push_back(due);
            oaddr_q.push_back(occ_addr_o);
            if (due_q.size() > acc_pkg::OCC_CREDITS) begin
                credit_err++;
                $display("more Occ requests outstanding than credits allow at %0t", $time);
            end
        end
        @(posedge clk);
        cyc++;
        #5;
        c_data_i = c_pend ? c_tab[c_addr_s] : 'x;   // one cycle rom
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
            occ_valid_i = 1'b1;
            occ_data_i  = occ_tab[oaddr_q.pop_front()];
            drop        = due_q.pop_front();
        end else begin
            occ_valid_i = 1'b0;
            occ_data_i  = 'x;
        end
    end

    //////////////////////////////////////////////////
    // host stimulus
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic load_task(input logic [3:0] addr, input logic [3:0] tag,
                             input logic [7:0] start, input logic [7:0] len);
        task_we_i    = 1'b1;
        task_waddr_i = addr;
        task_wdata_i = '0;
        task_wdata_i[acc_pkg::TASK_TAG_LSB +: 4]   = tag;
        task_wdata_i[acc_pkg::TASK_START_LSB +: 8] = start;
        task_wdata_i[acc_pkg::TASK_LEN_LSB +: 8]   = len;
        next_cycle();
        task_we_i = 1'b0;
    endtask

    task automatic run_batch();
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        while (!done_o) next_cycle();   // watchdog guards this
        next_cycle();
    endtask

    task automatic read_back();
        int slot;
        for (slot = 0; slot < 2**acc_pkg::RES_AW; slot++) begin
            rb          = 1'b1;
            res_raddr_i = slot[acc_pkg::RES_AW-1:0];
            next_cycle();
        end
        rb = 1'b0;
        next_cycle();   // last compare
    endtask

    initial begin
        seed_val = $urandom(89381);
        build_tables();
        arst_n_i     = 1'b0;
        start_i      = 1'b0;
        task_we_i    = 1'b0;
        task_waddr_i = '0;
        task_wdata_i = '0;
        res_raddr_i  = '0;
        rb           = 1'b0;
        c_data_i     = '0;
        occ_data_i   = '0;
        occ_valid_i  = 1'b0;
        repeat (16) @(posedge clk);
        #5 arst_n_i = 1'b1;
        read_back();   // all slots invalid after reset
        // batch one, short reads mostly found, long ones stop early
        load_task(4'd0, 4'd0, 8'd0,   8'd1);
        load_task(4'd1, 4'd1, 8'd4,   8'd2);
        load_task(4'd2, 4'd2, 8'd10,  8'd3);
        load_task(4'd3, 4'd3, 8'd20,  8'd2);
        load_task(4'd4, 4'd4, 8'd40,  8'd24);
        load_task(4'd5, 4'd5, 8'd70,  8'd32);
        load_task(4'd6, 4'd6, 8'd130, 8'd3);
        load_task(4'd7, 4'd7, 8'd200, 8'd20);
        run_batch();
        read_back();
        // batch two, queue continues at address 8
        load_task(4'd8,  4'd8,  8'd1,   8'd2);
        load_task(4'd9,  4'd9,  8'd33,  8'd3);
        load_task(4'd10, 4'd10, 8'd64,  8'd1);
        load_task(4'd11, 4'd11, 8'd99,  8'd2);
        load_task(4'd12, 4'd12, 8'd150, 8'd28);
        load_task(4'd13, 4'd13, 8'd180, 8'd32);
        load_task(4'd14, 4'd14, 8'd222, 8'd2);
        load_task(4'd15, 4'd15, 8'd224, 8'd32);
        run_batch();
        read_back();
        repeat (2) next_cycle();
        $display("errors: %0d value, %0d protocol, %0d credit", val_err, proto_err, credit_err);
        if (val_err == 0 && proto_err == 0 && credit_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WD_LIMIT);
        $display("watchdog expired before both batches finished");
        $display("Something failed");
        $finish;
    end

endmodule
